// ==== build.f ====
common/tcdm_pkg.sv
common/fifo_pkg.sv
fifo/sync_fifo.sv
rtl/initiator_port.sv
rtl/tcdm_fifo_top.sv
tb/tcdm_fifo_assertions.sv
tb/tb_tcdm_fifo.sv

// ==== tb/tb_tcdm_fifo.sv ====
`timescale 1ns/1ps

module tb_tcdm_fifo
  import tcdm_pkg::*;
  import fifo_pkg::*;
();

  logic              clk_i;
  logic              rst_ni;
  logic              clear_i;
  logic              empty_o;
  logic              tgt_req_i;
  logic              tgt_gnt_o;
  logic [ADDR_W-1:0] tgt_add_i;
  logic              tgt_wen_i;
  logic [BE_W-1:0]   tgt_be_i;
  logic [DATA_W-1:0] tgt_data_i;
  logic              tgt_r_valid_o;
  logic [DATA_W-1:0] tgt_r_data_o;
  logic              tgt_r_ready_i;
  logic              ini_req_o;
  logic              ini_gnt_i;
  logic [ADDR_W-1:0] ini_add_o;
  logic              ini_wen_o;
  logic [BE_W-1:0]   ini_be_o;
  logic [DATA_W-1:0] ini_data_o;
  logic              ini_r_valid_i;
  logic [DATA_W-1:0] ini_r_data_i;
  logic              ini_r_ready_o;

  logic              gnt_roll;   // memory willing to grant this cycle
  logic [31:0]       seed;
  int unsigned       checks;
  int unsigned       errors;
  int unsigned       timeouts;

  logic [ADDR_W+BE_W+DATA_W:0] issue_q [$];  // accepted requests {add, wen, be, data}
  logic [DATA_W-1:0]           read_q  [$];  // expected read responses, oldest first

  tcdm_fifo_top tcdm_fifo_top_inst (.*);

  // the memory grants only a raised request
  assign ini_gnt_i = gnt_roll & ini_req_o;

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;  // 40 ns period

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // lcg step
    return seed;
  endfunction

  // what the memory returns for a read of add
  function automatic logic [DATA_W-1:0] read_answer(input logic [ADDR_W-1:0] add);
    return add ^ 32'hdead_beef;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
  endtask

  // memory model, every granted read answers one cycle later
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      ini_r_valid_i <= 1'b0;
    end else begin
      ini_r_valid_i <= ini_req_o & ini_gnt_i & ini_wen_o;
      ini_r_data_i  <= read_answer(ini_add_o);
    end
  end

  // scoreboards, sampled on the edge before any update lands
  always @(posedge clk_i) begin : scoreboard
    logic [ADDR_W+BE_W+DATA_W:0] exp_word;
    if (rst_ni && clear_i) begin
      issue_q.delete();  // everything queued is flushed
      read_q.delete();
    end else if (rst_ni) begin
      if (tgt_r_valid_o && tgt_r_ready_i) begin
        if (read_q.size() == 0) begin
          errors++;
          $display("target response delivered with no read outstanding");
        end else begin
          check_value("resp_data", read_q.pop_front(), tgt_r_data_o);
        end
      end
      if (ini_req_o && ini_gnt_i) begin
        if (issue_q.size() == 0) begin
          errors++;
          $display("initiator request granted with no target request queued");
        end else begin
          exp_word = issue_q.pop_front();
          check_value("req_order", exp_word, {ini_add_o, ini_wen_o, ini_be_o, ini_data_o});
          if (exp_word[BE_W+DATA_W]) begin
            read_q.push_back(read_answer(exp_word[ADDR_W+BE_W+DATA_W -: ADDR_W]));
          end
        end
      end
      if (tgt_req_i && tgt_gnt_o) begin
        issue_q.push_back({tgt_add_i, tgt_wen_i, tgt_be_i, tgt_data_i});
      end
    end
  end

  task automatic run_random(input int unsigned cycles, input logic slow_ready);
    logic [31:0] r;
    repeat (cycles) begin
      @(posedge clk_i);
      r = next_rand();
      tgt_req_i     <= r[31];
      tgt_wen_i     <= r[30];
      gnt_roll      <= r[29] | r[28];                          // grants about 3 in 4
      tgt_r_ready_i <= slow_ready ? (r[27] & r[26]) : r[27];  // slow one fills the queue
      tgt_be_i      <= r[25:22];
      tgt_add_i     <= next_rand();
      tgt_data_i    <= next_rand();
    end
  endtask

  task automatic drain(input string what);
    int unsigned guard;
    guard = 0;
    @(posedge clk_i);
    tgt_req_i     <= 1'b0;
    gnt_roll      <= 1'b1;
    tgt_r_ready_i <= 1'b1;
    @(negedge clk_i);
    while (!(empty_o && issue_q.size() == 0 && read_q.size() == 0) && guard < 200) begin
      @(negedge clk_i);
      guard++;
    end
    if (!(empty_o && issue_q.size() == 0 && read_q.size() == 0)) begin
      note_timeout(what);
    end
  endtask

  // nine reads against a stalled memory, then a stalled consumer
  task automatic burst_and_throttle();
    int unsigned taken;
    int unsigned guard;
    taken = 0;
    guard = 0;
    @(posedge clk_i);
    gnt_roll      <= 1'b0;
    tgt_r_ready_i <= 1'b1;
    tgt_req_i     <= 1'b1;
    tgt_wen_i     <= 1'b1;  // reads only, every one comes back
    tgt_add_i     <= next_rand();
    while (taken < 8 && guard < 40) begin
      @(posedge clk_i);
      guard++;
      if (tgt_gnt_o) begin
        taken++;
      end
      tgt_add_i  <= next_rand();
      tgt_data_i <= next_rand();
    end
    if (taken < 8) begin
      note_timeout("eight queued requests");
    end
    @(negedge clk_i);
    check_value("burst_gnt", 1'b0, tgt_gnt_o);
    check_value("burst_cycles", 8, guard);  // empty queue takes one per cycle
    @(posedge clk_i);
    gnt_roll      <= 1'b1;
    tgt_r_ready_i <= 1'b0;  // consumer stalls from here on
    guard = 0;
    while (taken < 9 && guard < 40) begin
      @(posedge clk_i);
      guard++;
      if (tgt_gnt_o) begin
        taken++;
      end
    end
    tgt_req_i <= 1'b0;
    if (taken < 9) begin
      note_timeout("the ninth request");
    end
    guard = 0;
    @(negedge clk_i);
    while (ini_r_ready_o && guard < 40) begin
      @(negedge clk_i);
      guard++;
    end
    if (ini_r_ready_o) begin
      note_timeout("the response fifo to fill");
    end
    check_value("throttle_req", 2'b01, {ini_req_o, tgt_r_valid_o});
    check_value("throttle_held", 1, issue_q.size());  // eight answers fit, the ninth waits
  endtask

  task automatic clear_while_busy();
    @(negedge clk_i);
    check_value("clear_busy", 1'b0, empty_o);  // traffic still queued
    @(posedge clk_i);
    gnt_roll <= 1'b0;
    clear_i  <= 1'b1;
    @(posedge clk_i);
    clear_i  <= 1'b0;
    @(negedge clk_i);
    check_value("clear_state", 3'b100, {empty_o, ini_req_o, tgt_r_valid_o});
  endtask

  initial begin
    seed          = 32'h1a9b_d228;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    tgt_req_i     = 1'b0;
    tgt_add_i     = '0;
    tgt_wen_i     = 1'b0;
    tgt_be_i      = '0;
    tgt_data_i    = '0;
    tgt_r_ready_i = 1'b0;
    gnt_roll      = 1'b0;
    ini_r_valid_i = 1'b0;
    ini_r_data_i  = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("reset_state", 5'b00111,
                {ini_req_o, tgt_r_valid_o, tgt_gnt_o, empty_o, ini_r_ready_o});

    run_random(300, 1'b0);
    run_random(300, 1'b1);  // response queue runs full
    drain("random traffic to drain");
    burst_and_throttle();
    clear_while_busy();
    run_random(200, 1'b0);  // still works after the flush
    drain("traffic after clear to drain");
    @(negedge clk_i);
    check_value("drain", 0, issue_q.size() + read_q.size());

    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts,
             tcdm_fifo_top_inst.u_tcdm_fifo_assertions.fail_cnt);
    if (errors == 0 && timeouts == 0 &&
        tcdm_fifo_top_inst.u_tcdm_fifo_assertions.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/tcdm_fifo_assertions.sv ====
`timescale 1ns/1ps

module tcdm_fifo_assertions
  import tcdm_pkg::*;
  import fifo_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              clear_i,
  input logic              empty_i,
  input logic              tgt_gnt_i,
  input logic              tgt_r_valid_i,
  input logic              tgt_r_ready_i,
  input logic [DATA_W-1:0] tgt_r_data_i,
  input logic              ini_req_i,
  input logic              ini_gnt_i,
  input logic [REQ_W-1:0]  ini_word_i,    // head of the request queue
  input logic              resp_full_i,
  input logic              hold_valid_i   // pending flag of the hold register
);

  int unsigned fail_cnt;  // number of failed assertions so far

  initial fail_cnt = 0;

  // first sampled cycle out of reset
  assert property (@(posedge clk_i) $rose(rst_ni) |->
      !ini_req_i && !tgt_r_valid_i && !hold_valid_i && tgt_gnt_i && empty_i)
    else begin
      fail_cnt++;
      $error("state after reset is wrong");
    end

  // no new request while a response has nowhere to go
  assert property (@(posedge clk_i) disable iff (!rst_ni) resp_full_i |-> !ini_req_i)
    else begin
      fail_cnt++;
      $error("initiator request raised while the response fifo is full");
    end

  // a waiting request keeps its fields
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      ini_req_i && !ini_gnt_i && !clear_i |=> $stable(ini_word_i))
    else begin
      fail_cnt++;
      $error("request fields changed before the grant");
    end

  // a stalled response stays valid and unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      tgt_r_valid_i && !tgt_r_ready_i && !clear_i |=> tgt_r_valid_i && $stable(tgt_r_data_i))
    else begin
      fail_cnt++;
      $error("response dropped or changed while the target stalled");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      clear_i |=> empty_i && !ini_req_i && !tgt_r_valid_i && !hold_valid_i)
    else begin
      fail_cnt++;
      $error("clear did not flush both queues and the hold register");
    end

endmodule

bind tcdm_fifo_top tcdm_fifo_assertions u_tcdm_fifo_assertions (
  .clk_i         ( clk_i                         ),
  .rst_ni        ( rst_ni                        ),
  .clear_i       ( clear_i                       ),
  .empty_i       ( empty_o                       ),
  .tgt_gnt_i     ( tgt_gnt_o                     ),
  .tgt_r_valid_i ( tgt_r_valid_o                 ),
  .tgt_r_ready_i ( tgt_r_ready_i                 ),
  .tgt_r_data_i  ( tgt_r_data_o                  ),
  .ini_req_i     ( ini_req_o                     ),
  .ini_gnt_i     ( ini_gnt_i                     ),
  .ini_word_i    ( req_pop_data                  ),
  .resp_full_i   ( resp_full                     ),
  .hold_valid_i  ( u_initiator_port.hold_valid_q )
);

// ==== rtl/tcdm_fifo_top.sv ====
`timescale 1ns/1ps

module tcdm_fifo_top
  import tcdm_pkg::*;
  import fifo_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,       // flush both queues and the hold register
  output logic              empty_o,       // both queues empty

  // target side, requests in and responses out
  input  logic              tgt_req_i,
  output logic              tgt_gnt_o,
  input  logic [ADDR_W-1:0] tgt_add_i,
  input  logic              tgt_wen_i,     // 1 reads
  input  logic [BE_W-1:0]   tgt_be_i,
  input  logic [DATA_W-1:0] tgt_data_i,
  output logic              tgt_r_valid_o,
  output logic [DATA_W-1:0] tgt_r_data_o,
  input  logic              tgt_r_ready_i, // response back-pressure from the consumer

  // initiator side, requests out and responses in
  output logic              ini_req_o,
  input  logic              ini_gnt_i,
  output logic [ADDR_W-1:0] ini_add_o,
  output logic              ini_wen_o,
  output logic [BE_W-1:0]   ini_be_o,
  output logic [DATA_W-1:0] ini_data_o,
  input  logic              ini_r_valid_i,
  input  logic [DATA_W-1:0] ini_r_data_i,
  output logic              ini_r_ready_o
);

  // request queue
  logic [REQ_W-1:0]  req_push_data;
  logic [REQ_W-1:0]  req_pop_data;
  logic              req_full;
  logic              req_valid;
  logic              req_empty;

  // response queue
  logic              resp_push;
  logic [DATA_W-1:0] resp_push_data;
  logic              resp_full;
  logic              resp_almost_full;
  logic              resp_empty;

  // request word, add on top and wen in the lsb
  assign req_push_data = {tgt_add_i, tgt_data_i, tgt_be_i, tgt_wen_i};

  assign tgt_gnt_o = ~req_full;  // accept while there is room

  // unpack the head of the request queue onto the initiator bus
  assign ini_add_o  = req_pop_data[REQ_ADD_LSB  +: ADDR_W];
  assign ini_data_o = req_pop_data[REQ_DATA_LSB +: DATA_W];
  assign ini_be_o   = req_pop_data[REQ_BE_LSB   +: BE_W];
  assign ini_wen_o  = req_pop_data[REQ_WEN_LSB];

  assign empty_o = req_empty & resp_empty;

  sync_fifo #(
    .DATA_WIDTH ( REQ_W )
  ) u_req_fifo (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .push_i        ( tgt_req_i     ),  // req while full is dropped, gnt is low then
    .data_i        ( req_push_data ),
    .full_o        ( req_full      ),
    .almost_full_o (               ),
    .pop_i         ( ini_gnt_i     ),  // memory grants only a raised req
    .data_o        ( req_pop_data  ),
    .valid_o       ( req_valid     ),
    .empty_o       ( req_empty     )
  );

  // throttles requests and feeds responses into the response queue
  initiator_port u_initiator_port (
    .clk_i              ( clk_i            ),
    .rst_ni             ( rst_ni           ),
    .clear_i            ( clear_i          ),
    .req_valid_i        ( req_valid        ),
    .ini_req_o          ( ini_req_o        ),
    .ini_r_valid_i      ( ini_r_valid_i    ),
    .ini_r_data_i       ( ini_r_data_i     ),
    .ini_r_ready_o      ( ini_r_ready_o    ),
    .tgt_r_ready_i      ( tgt_r_ready_i    ),
    .resp_full_i        ( resp_full        ),
    .resp_almost_full_i ( resp_almost_full ),
    .resp_push_o        ( resp_push        ),
    .resp_data_o        ( resp_push_data   )
  );

  sync_fifo #(
    .DATA_WIDTH ( DATA_W )
  ) u_resp_fifo (
    .clk_i         ( clk_i                         ),
    .rst_ni        ( rst_ni                        ),
    .clear_i       ( clear_i                       ),
    .push_i        ( resp_push                     ),
    .data_i        ( resp_push_data                ),
    .full_o        ( resp_full                     ),
    .almost_full_o ( resp_almost_full              ),
    .pop_i         ( tgt_r_ready_i & tgt_r_valid_o ),  // pop on target handshake
    .data_o        ( tgt_r_data_o                  ),
    .valid_o       ( tgt_r_valid_o                 ),
    .empty_o       ( resp_empty                    )
  );

endmodule

// ==== rtl/initiator_port.sv ====
`timescale 1ns/1ps

module initiator_port
  import tcdm_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,             // drops a pending held response

  // request side
  input  logic              req_valid_i,         // request fifo has an entry
  output logic              ini_req_o,           // throttled request to the memory

  // response side from the memory
  input  logic              ini_r_valid_i,
  input  logic [DATA_W-1:0] ini_r_data_i,
  output logic              ini_r_ready_o,

  // target consumer and response fifo state
  input  logic              tgt_r_ready_i,       // target will pop this cycle if valid
  input  logic              resp_full_i,
  input  logic              resp_almost_full_i,

  // push into the response fifo
  output logic              resp_push_o,
  output logic [DATA_W-1:0] resp_data_o
);

  logic              hold_valid_q;   // a response is waiting in the hold register
  logic [DATA_W-1:0] hold_data_q;    // copy of the last response seen
  logic              resp_ready;     // response fifo takes a push this cycle
  logic              last_slot_hit;  // incoming response takes the last free slot

  assign resp_ready = ~resp_full_i;

  // one slot left, a response lands in it and nobody drains the fifo
  assign last_slot_hit = resp_almost_full_i & ini_r_valid_i & ~tgt_r_ready_i;

  // issue only when the response of this request has somewhere to go
  assign ini_req_o = req_valid_i & ~resp_full_i & ~last_slot_hit;

  assign ini_r_ready_o = resp_ready;

  // live response has priority, the held copy goes out when the bus is quiet
  assign resp_push_o = ini_r_valid_i | hold_valid_q;
  assign resp_data_o = ini_r_valid_i ? ini_r_data_i : hold_data_q;

  // pending flag of the hold register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else begin
      if (ini_r_valid_i && resp_ready) begin
        hold_valid_q <= 1'b0;            // live response went straight in
      end else if (ini_r_valid_i) begin
        hold_valid_q <= 1'b1;            // refused, keep it for later
      end else if (hold_valid_q && resp_ready) begin
        hold_valid_q <= 1'b0;            // held copy pushed now
      end
    end
  end

  // the held data is only looked at while the flag is set
  always_ff @(posedge clk_i) begin
    if (ini_r_valid_i) begin
      hold_data_q <= ini_r_data_i;
    end
  end

endmodule

// ==== fifo/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
  import fifo_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32  // payload width of one entry
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,        // synchronous flush, wins over push and pop

  // write side
  input  logic                  push_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic                  full_o,
  output logic                  almost_full_o,  // exactly one entry left

  // read side
  input  logic                  pop_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  valid_o,
  output logic                  empty_o
);

  // storage, flip-flop based
  logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;   // next slot to write
  logic [PTR_W-1:0] rd_ptr_q;   // oldest valid slot
  logic [CNT_W-1:0] cnt_q;      // number of valid entries

  logic full;
  logic empty;
  logic push_ok;                // push that is actually taken
  logic pop_ok;                 // pop that is actually taken

  // status flags straight from the registered count
  assign full  = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign empty = (cnt_q == '0);

  assign full_o        = full;
  assign almost_full_o = (cnt_q == CNT_W'(FIFO_DEPTH - 1));
  assign empty_o       = empty;
  assign valid_o       = ~empty;

  // push into full and pop from empty are dropped silently
  assign push_ok = push_i & ~full;
  assign pop_ok  = pop_i & ~empty;

  // head of queue, no bypass from data_i
  assign data_o = mem_q[rd_ptr_q];

  // write pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
    end else if (push_ok) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at FIFO_DEPTH
    end
  end

  // read pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
    end else if (pop_ok) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // occupancy count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;   // push only
        2'b01:   cnt_q <= cnt_q - 1'b1;   // pop only
        default: cnt_q <= cnt_q;          // none, or both at once
      endcase
    end
  end

  // payload write, entries are only read once the count covers them
  always_ff @(posedge clk_i) begin
    if (push_ok && !clear_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== common/fifo_pkg.sv ====
package fifo_pkg;

  import tcdm_pkg::*;

  // entries per queue, must stay a power of two so the pointers wrap for free
  localparam int unsigned FIFO_DEPTH = 8;

  // read and write pointer width
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  // occupancy count, one extra bit to tell full from empty
  localparam int unsigned CNT_W = PTR_W + 1;

  // request word as queued: add, data, be, wen from msb down to lsb
  localparam int unsigned REQ_W = ADDR_W + DATA_W + BE_W + 1;

  // bit offsets of the fields inside the request word
  localparam int unsigned REQ_WEN_LSB  = 0;
  localparam int unsigned REQ_BE_LSB   = 1;
  localparam int unsigned REQ_DATA_LSB = REQ_BE_LSB + BE_W;
  localparam int unsigned REQ_ADD_LSB  = REQ_DATA_LSB + DATA_W;

endpackage

// ==== common/tcdm_pkg.sv ====
package tcdm_pkg;

  // bus geometry of the TCDM port, shared by target and initiator side

  // byte address, full 32 bit space
  localparam int unsigned ADDR_W = 32;

  // one data word per request and per response
  localparam int unsigned DATA_W = 32;

  // one enable bit per byte lane
  localparam int unsigned BE_W = DATA_W / 8;

  // wen polarity on the bus: 1 reads, 0 writes
  localparam logic WEN_READ  = 1'b1;
  localparam logic WEN_WRITE = 1'b0;

  // all lanes enabled, the usual value for a full word access
  localparam logic [BE_W-1:0] BE_ALL = {BE_W{1'b1}};

  // response payload is the bare read data, no sideband
  localparam int unsigned RESP_W = DATA_W;

endpackage
